/* rtl/usbLinePkg.sv */
package usbLinePkg;

    // bit timing of the 12 Mbit/s full-speed line against clk48
    localparam logic [2:0] bitPeriod = 3'd4;    // clk48 cycles per bit
    localparam logic [2:0] samplePhase = 3'd2;  // sample two cycles after an edge, mid bit

    // a zero is stuffed after this many consecutive ones
    localparam logic [2:0] stuffLimit = 3'd6;

    // KJKJKJKK decodes to seven zeros and a one
    // bits arrive LSB first, so the assembled byte reads 8'h80
    localparam logic [7:0] syncPattern = 8'h80;

    // packet receive FSM
    typedef enum logic [2:0] {
        idle,     // line at J, waiting for the first K
        sync,     // shifting in bits until the SYNC pattern lines up
        data,     // unstuffing and assembling bytes
        eopWait,  // SE0 seen, waiting for the closing J
        error     // broken packet, ignore bits until SE0
    } rxState;

endpackage

/* rtl/usbPacketPkg.sv */
package usbPacketPkg;

    // 4-bit PID codes, the low nibble of the PID byte
    typedef enum logic [3:0] {
        out   = 4'b0001,  // tokens carry a CRC5
        in    = 4'b1001,
        sof   = 4'b0101,
        setup = 4'b1101,
        data0 = 4'b0011,  // data packets carry a CRC16
        data1 = 4'b1011,
        ack   = 4'b0010,  // handshakes have no CRC at all
        nak   = 4'b1010,
        stall = 4'b1110
    } pidType;

    // which CRC check applies to the packet in flight
    typedef enum logic [1:0] {
        none,
        crc5,
        crc16
    } crcMode;

    localparam logic [4:0] crc5Poly = 5'h05;         // x^5 + x^2 + 1
    localparam logic [15:0] crc16Poly = 16'h8005;    // x^16 + x^15 + x^2 + 1
    localparam logic [4:0] crc5Residue = 5'b01100;   // left in the register by a good token
    localparam logic [15:0] crc16Residue = 16'h800D; // same for a good data packet

    // output FIFO entries
    localparam logic [4:0] bufferDepth = 5'd16;

endpackage

/* rtl/usbRxFrontend.sv */
module usbRxFrontend (
    input  logic clk48,
    input  logic reset,
    input  logic usbDp,
    input  logic usbDn,
    output logic dataInP,
    output logic isValidDPSignal,
    output logic eopDetected
);

    // bit 0 is the first flop and may go metastable, bit 1 is safe to use
    logic [1:0] dpSync;
    logic [1:0] dnSync;

    always_ff @(posedge clk48) begin
        if (reset) begin
            dpSync <= 2'b11;  // start out in J, which is D+ high at full speed
            dnSync <= 2'b00;
        end else begin
            dpSync <= {dpSync[0], usbDp};
            dnSync <= {dnSync[0], usbDn};
        end
    end

    // two flops from the pin to dataInP
    assign dataInP = dpSync[1];

    // J or K, the only states that carry a bit
    assign isValidDPSignal = dpSync[1] ^ dnSync[1];

    // single-ended zero, held for as long as both lines sit low
    assign eopDetected = !dpSync[1] && !dnSync[1];

    // a full-speed host never drives both lines high
    noSeOne: assert property (@(posedge clk48) disable iff (reset)
        !(dpSync[1] && dnSync[1]))
        else $error("SE1 on the USB pins");

endmodule

/* rtl/usbRxClockRecovery.sv */
module usbRxClockRecovery (
    input  logic clk48,
    input  logic reset,
    input  logic dataInP,
    output logic bitStrobe
);
    import usbLinePkg::*;

    logic dataInPrev;      // dataInP one cycle ago, for edge detection
    logic lineEdge;
    logic [2:0] phase;     // cycles since the last edge, modulo bitPeriod
    logic [2:0] phaseNext;

    assign lineEdge = dataInP != dataInPrev;

    // every edge pulls the phase back so that the next sample lands mid bit
    always_comb begin
        if (lineEdge) begin
            phaseNext = 3'd1;  // the edge cycle itself counts as phase 0
        end else if (phase == bitPeriod - 3'd1) begin
            phaseNext = 3'd0;
        end else begin
            phaseNext = phase + 3'd1;  // free running, covers long runs without edges
        end
    end

    always_ff @(posedge clk48) begin
        if (reset) begin
            dataInPrev <= 1'b1;  // J
            phase <= 3'd0;
            bitStrobe <= 1'b0;
        end else begin
            dataInPrev <= dataInP;
            phase <= phaseNext;
            bitStrobe <= phaseNext == samplePhase;  // high while phase sits at samplePhase
        end
    end

    // strobes stay at least bitPeriod - 1 cycles apart, even across re-centering
    strobeSpacing: assert property (@(posedge clk48) disable iff (reset)
        bitStrobe |=> !bitStrobe [*(bitPeriod - 2)])
        else $error("bit strobes too close together");

endmodule

/* rtl/usbRxDecoder.sv */
module usbRxDecoder (
    input  logic clk48,
    input  logic reset,
    input  logic dataInP,
    input  logic isValidDPSignal,
    input  logic eopDetected,
    input  logic bitStrobe,
    output logic [7:0] byteData,
    output logic byteStrobe,
    output logic packetEnd,
    output logic packetFault,
    output logic crcClear,
    output usbPacketPkg::crcMode crcSelect,
    output logic crcBit,
    output logic crcBitValid
);
    import usbLinePkg::*;
    import usbPacketPkg::*;

    rxState state;
    logic prevLine;         // line level at the previous strobe
    logic nrziBit;
    logic [7:0] shiftReg;
    logic [7:0] shiftNext;
    logic [2:0] bitCount;   // unstuffed bits in the current byte
    logic [2:0] onesCount;  // consecutive ones since the last zero
    logic stuffedSlot;
    logic pidDone;          // the PID byte is already in
    pidType pid;

    assign nrziBit = dataInP == prevLine;       // no transition means a one
    assign shiftNext = {nrziBit, shiftReg[7:1]};  // LSB arrives first
    assign stuffedSlot = onesCount == stuffLimit;  // this bit must be the stuffed zero
    assign pid = pidType'(shiftNext[3:0]);

    always_ff @(posedge clk48) begin
        byteStrobe <= 1'b0;  // all pulses last one cycle
        packetEnd <= 1'b0;
        crcClear <= 1'b0;
        crcBitValid <= 1'b0;
        if (reset) begin
            state <= idle;
            prevLine <= 1'b1;
            shiftReg <= '0;
            bitCount <= '0;
            onesCount <= '0;
            pidDone <= 1'b0;
            packetFault <= 1'b0;
            crcSelect <= none;
        end else if (bitStrobe) begin
            prevLine <= dataInP;
            case (state)
                idle: begin
                    if (isValidDPSignal && !dataInP) begin  // first K of SYNC
                        state <= sync;
                        shiftReg <= {nrziBit, 7'h7F};  // ones so the match needs all seven zeros
                    end
                end
                sync: begin
                    shiftReg <= shiftNext;
                    if (eopDetected) begin
                        state <= idle;  // noise, not a packet
                    end else if (shiftNext == syncPattern) begin
                        state <= data;
                        crcClear <= 1'b1;
                        crcSelect <= none;
                        packetFault <= 1'b0;
                        bitCount <= '0;
                        onesCount <= 3'd1;  // the closing one of SYNC counts toward stuffing
                        pidDone <= 1'b0;
                    end
                end
                data: begin
                    if (eopDetected) begin
                        state <= eopWait;
                        if (bitCount != 3'd0) packetFault <= 1'b1;  // EOP mid byte
                    end else if (!isValidDPSignal) begin
                        state <= error;
                        packetFault <= 1'b1;
                    end else if (stuffedSlot) begin
                        onesCount <= '0;  // drop the stuffed zero
                        if (nrziBit) begin
                            state <= error;  // a seventh one in a row
                            packetFault <= 1'b1;
                        end
                    end else begin
                        shiftReg <= shiftNext;
                        bitCount <= bitCount + 3'd1;
                        onesCount <= nrziBit ? onesCount + 3'd1 : 3'd0;
                        crcBit <= nrziBit;
                        crcBitValid <= pidDone;  // the CRC covers everything after the PID
                        if (bitCount == 3'd7) begin
                            byteStrobe <= 1'b1;
                            byteData <= shiftNext;
                            if (!pidDone) begin
                                pidDone <= 1'b1;
                                // upper nibble must be the complement of the PID
                                if (shiftNext[7:4] != ~shiftNext[3:0]) packetFault <= 1'b1;
                                case (pid)
                                    out, in, sof, setup: crcSelect <= crc5;
                                    data0, data1: crcSelect <= crc16;
                                    ack, nak, stall: crcSelect <= none;
                                    default: packetFault <= 1'b1;  // reserved or unsupported
                                endcase
                            end
                        end
                    end
                end
                error: begin
                    if (eopDetected) state <= eopWait;
                end
                eopWait: begin
                    if (!eopDetected) begin  // back to J, the packet is over
                        packetEnd <= 1'b1;
                        state <= idle;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    // bytes only come out of a packet body, while the line still carries the bit just sampled
    byteInData: assert property (@(posedge clk48) disable iff (reset)
        byteStrobe |-> state == data && isValidDPSignal)
        else $error("byte strobe outside the data state or off the bit center");

endmodule

/* rtl/usbCrc.sv */
module usbCrc (
    input  logic clk48,
    input  logic reset,
    input  logic crcClear,
    input  usbPacketPkg::crcMode crcSelect,
    input  logic crcBit,
    input  logic crcBitValid,
    output logic crcGood
);
    import usbPacketPkg::*;

    logic [4:0] crc5Reg;
    logic [15:0] crc16Reg;
    logic crc5Feedback;
    logic crc16Feedback;

    // incoming bit against the register MSB decides whether the polynomial folds in
    assign crc5Feedback = crcBit ^ crc5Reg[4];
    assign crc16Feedback = crcBit ^ crc16Reg[15];

    // both registers run, the mode only picks which one is checked
    always_ff @(posedge clk48) begin
        if (reset || crcClear) begin
            crc5Reg <= '1;  // USB presets to all ones
            crc16Reg <= '1;
        end else if (crcBitValid) begin
            crc5Reg <= {crc5Reg[3:0], 1'b0} ^ ({5{crc5Feedback}} & crc5Poly);
            crc16Reg <= {crc16Reg[14:0], 1'b0} ^ ({16{crc16Feedback}} & crc16Poly);
        end
    end

    // after the CRC bits themselves a good packet leaves the fixed residue
    always_comb begin
        case (crcSelect)
            crc5: crcGood = crc5Reg == crc5Residue;
            crc16: crcGood = crc16Reg == crc16Residue;
            default: crcGood = 1'b1;  // handshakes have nothing to check
        endcase
    end

endmodule

/* rtl/usbRxOutput.sv */
module usbRxOutput (
    input  logic clk48,
    input  logic reset,
    input  logic [7:0] byteData,
    input  logic byteStrobe,
    input  logic packetEnd,
    input  logic packetFault,
    input  logic crcGood,
    input  logic rxAcceptNewData,
    output logic [7:0] rxData,
    output logic rxDataValid,
    output logic rxIsLastByte,
    output logic keepPacket
);
    import usbPacketPkg::*;

    logic [9:0] fifoMem [bufferDepth];  // keep flag, last flag, byte
    logic [9:0] headEntry;
    logic [$clog2(bufferDepth)-1:0] wrPtr;
    logic [$clog2(bufferDepth)-1:0] rdPtr;
    logic [4:0] fillCount;
    logic [7:0] holdByte;  // newest byte, waiting to learn if it ends the packet
    logic holdValid;
    logic holdLast;        // held byte is the last one and only waits for room
    logic holdKeep;
    logic overflow;        // a byte of this packet was dropped
    logic fifoFull;
    logic takeByte;
    logic push;
    logic pop;

    assign fifoFull = fillCount == bufferDepth;
    assign takeByte = byteStrobe && !(holdValid && fifoFull);  // else the new byte is lost
    assign push = holdValid && !fifoFull && (byteStrobe || holdLast);
    assign pop = rxDataValid && rxAcceptNewData;

    always_ff @(posedge clk48) begin
        if (push) fifoMem[wrPtr] <= {holdKeep, holdLast, holdByte};
        if (takeByte) holdByte <= byteData;
        if (packetEnd && !holdLast) holdKeep <= crcGood && !packetFault && !overflow;
    end

    always_ff @(posedge clk48) begin
        if (reset) begin
            wrPtr <= '0;
            rdPtr <= '0;
            fillCount <= '0;
            holdValid <= 1'b0;
            holdLast <= 1'b0;
            overflow <= 1'b0;
        end else begin
            if (push) wrPtr <= wrPtr + 1'b1;
            if (pop) rdPtr <= rdPtr + 1'b1;
            fillCount <= fillCount + 5'(push) - 5'(pop);
            if (takeByte) begin
                holdValid <= 1'b1;
                holdLast <= 1'b0;
            end else if (push) begin
                holdValid <= 1'b0;  // the pending last byte went into the FIFO
                holdLast <= 1'b0;
            end else if (packetEnd) begin
                holdLast <= holdValid;
            end
            if (byteStrobe && !takeByte) overflow <= 1'b1;
            else if (packetEnd) overflow <= 1'b0;  // verdict taken, start clean
        end
    end

    assign headEntry = fifoMem[rdPtr];
    assign rxDataValid = fillCount != 5'd0;
    assign rxData = headEntry[7:0];
    assign rxIsLastByte = rxDataValid && headEntry[8];
    assign keepPacket = rxIsLastByte && headEntry[9];  // verdict rides on the last byte

    // a waiting byte must not change under the backend
    holdWhileStalled: assert property (@(posedge clk48) disable iff (reset)
        rxDataValid && !rxAcceptNewData |=> rxDataValid && $stable(rxData))
        else $error("rxData changed while not accepted");

endmodule

/* rtl/usbRxTop.sv */
module usbRxTop (
    input  logic clk48,
    input  logic reset,
    input  logic usbDp,
    input  logic usbDn,
    input  logic rxAcceptNewData,  // backend can take the byte on rxData
    output logic [7:0] rxData,
    output logic rxDataValid,
    output logic rxIsLastByte,     // rxData closes the packet
    output logic keepPacket        // packet verdict, read together with rxIsLastByte
);
    import usbPacketPkg::*;

    // line side
    logic dataInP;
    logic isValidDPSignal;
    logic eopDetected;
    logic bitStrobe;

    // decoder results
    logic [7:0] byteData;
    logic byteStrobe;
    logic packetEnd;
    logic packetFault;

    // CRC path
    logic crcClear;
    crcMode crcSelect;
    logic crcBit;
    logic crcBitValid;
    logic crcGood;

    // all port names match the nets above
    usbRxFrontend i_usbRxFrontend (.*);
    usbRxClockRecovery i_usbRxClockRecovery (.*);
    usbRxDecoder i_usbRxDecoder (.*);
    usbCrc i_usbCrc (.*);
    usbRxOutput i_usbRxOutput (.*);

endmodule

/* test/usbRxTb.sv */
module usbRxTb;

    localparam int caseCount = 11;
    localparam int caseWords = 16;  // id, kind, keep, length and twelve packet bytes

    logic clk48 = 1'b0;
    logic reset = 1'b1;
    logic usbDp = 1'b1;  // the idle full-speed line sits in J
    logic usbDn = 1'b0;
    logic rxAcceptNewData = 1'b0;
    logic [7:0] rxData;
    logic rxDataValid;
    logic rxIsLastByte;
    logic keepPacket;

    logic [7:0] caseMem [caseCount * caseWords];
    logic [1:0] lineQueue [$];    // {D+, D-} for every bit time on the wire
    logic [17:0] expectQueue [$]; // case id, keep, last, byte
    logic lineLevel;              // D+ level of the last coded bit
    int onesRun;                  // ones since the last zero, for stuffing
    integer seed = 32'he347bfc4;
    int cycleCount = 0;
    int cycleLimit = 0;
    int casesDone = 0;
    int casesFailed = 0;
    int caseErrors = 0;
    int caseBytes = 0;
    int totalErrors = 0;
    logic stalled = 1'b0;         // the byte on rxData was offered and refused
    logic [7:0] stalledData;

    usbRxTop i_usbRxTop (.*);

    always #4 clk48 = ~clk48;

    // NRZI, a zero toggles the line and a one leaves it alone
    task automatic codeBit(input logic b);
        if (!b) begin
            lineLevel = !lineLevel;
        end
        lineQueue.push_back({lineLevel, !lineLevel});
    endtask

    // flip corrupts the coded bit, stuffing still follows the true bit
    task automatic sendBit(input logic b, input logic flip);
        codeBit(b ^ flip);
        if (b) begin
            onesRun++;
            if (onesRun == 6) begin
                codeBit(1'b0);  // stuffed zero after six ones
                onesRun = 0;
            end
        end else begin
            onesRun = 0;
        end
    endtask

    // puts one case on the line queue and its bytes on the expect queue
    task automatic buildCase(input int c);
        logic [7:0] id;
        logic [7:0] value;
        logic keep;
        int kind;
        int length;
        int outCount;
        id = caseMem[c * caseWords];
        kind = int'(caseMem[c * caseWords + 1]);
        keep = caseMem[c * caseWords + 2][0];
        length = int'(caseMem[c * caseWords + 3]);
        lineLevel = 1'b1;
        onesRun = 0;
        for (int i = 0; i < 8; i++) begin
            sendBit(i == 7, 1'b0);  // SYNC is seven zeros and a one
        end
        for (int k = 0; k < length; k++) begin
            value = caseMem[c * caseWords + 4 + k];
            for (int j = 0; j < 8; j++) begin
                sendBit(value[j], kind == 2 && k == 1 && j == 0);
            end
            if (kind == 1 && k == 0) begin
                repeat (7) codeBit(1'b1);  // a run of seven ones with no stuffed zero
            end
        end
        repeat (2) lineQueue.push_back(2'b00);  // EOP is two SE0 bits
        repeat (4) lineQueue.push_back(2'b10);  // then J, which stays as the idle gap
        // a stuff error right after the PID leaves only the PID byte
        outCount = (kind == 1) ? 1 : length;
        for (int k = 0; k < outCount; k++) begin
            value = caseMem[c * caseWords + 4 + k];
            if (kind == 2 && k == 1) begin
                value[0] = !value[0];  // the flipped bit arrives as sent
            end
            expectQueue.push_back({id, keep, k == outCount - 1, value});
        end
    endtask

    // random back-pressure from the backend
    always @(posedge clk48) begin
        int randomValue;
        randomValue = $random(seed);
        rxAcceptNewData <= randomValue[0];
    end

    always @(posedge clk48) begin
        cycleCount <= cycleCount + 1;
        if (cycleLimit != 0 && cycleCount > cycleLimit) begin
            $display("timeout after %0d cycles, %0d of %0d cases done",
                     cycleCount, casesDone, caseCount);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    // outputs are settled at the falling edge, a pop happens at the next rising edge
    always @(negedge clk48) begin
        logic [17:0] expected;
        if (stalled) begin
            assert (rxDataValid && rxData == stalledData) else begin
                $display("rxData or rxDataValid changed while the byte was refused");
                caseErrors++;
                totalErrors++;
            end
        end
        if (rxDataValid && rxAcceptNewData) begin
            assert (expectQueue.size() != 0) else begin
                $display("a byte came out after every expected byte was taken");
                totalErrors++;
            end
            if (expectQueue.size() != 0) begin
                expected = expectQueue.pop_front();
                caseBytes++;
                assert (rxData == expected[7:0]) else begin
                    $display("Error: case %02h rxData expected %02h actual %02h",
                             expected[17:10], expected[7:0], rxData);
                    caseErrors++;
                    totalErrors++;
                end
                assert (rxIsLastByte == expected[8]) else begin
                    $display("Error: case %02h rxIsLastByte expected %0b actual %0b",
                             expected[17:10], expected[8], rxIsLastByte);
                    caseErrors++;
                    totalErrors++;
                end
                if (expected[8]) begin
                    assert (keepPacket == expected[9]) else begin
                        $display("Error: case %02h keepPacket expected %0b actual %0b",
                                 expected[17:10], expected[9], keepPacket);
                        caseErrors++;
                        totalErrors++;
                    end
                    $display("case %02h finished with %0d bytes and %0d errors",
                             expected[17:10], caseBytes, caseErrors);
                    if (caseErrors != 0) begin
                        casesFailed++;
                    end
                    casesDone++;
                    caseErrors = 0;
                    caseBytes = 0;
                end
            end
        end
        stalled = rxDataValid && !rxAcceptNewData;
        stalledData = rxData;
    end

    initial begin
        $readmemh("test/usbRxCases.hex", caseMem);
        for (int c = 0; c < caseCount; c++) begin
            buildCase(c);
        end
        cycleLimit = lineQueue.size() * 4 + 200 * caseCount;
        repeat (8) @(posedge clk48);
        reset <= 1'b0;
        // two more edges put every pin change on the PLL's free-running bit grid
        repeat (2) @(posedge clk48);
        while (lineQueue.size() != 0) begin
            {usbDp, usbDn} <= lineQueue.pop_front();
            repeat (4) @(posedge clk48);  // 48 MHz over 12 Mbit/s
        end
        wait (casesDone == caseCount);
        $display("%0d cases run, %0d failed, %0d errors", casesDone, casesFailed, totalErrors);
        if (totalErrors == 0 && casesFailed == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* test/usbRxCases.hex */
// id, kind, expected keep, length, then twelve packet bytes with the CRC included
// kind 0 is clean, 1 puts seven ones after the PID, 2 flips the first bit after the PID
01 0 1 0C C3 31 32 33 34 35 36 37 38 39 C8 B4  // DATA0 with a nine byte payload
02 0 1 03 69 00 10 00 00 00 00 00 00 00 00 00  // IN to address 0, endpoint 0
03 0 1 01 D2 00 00 00 00 00 00 00 00 00 00 00  // ACK
04 0 1 05 C3 FF FF FF FF 00 00 00 00 00 00 00  // DATA0, long runs of ones
05 0 1 03 69 FF 47 00 00 00 00 00 00 00 00 00  // IN to address 7F, endpoint F
06 0 1 03 4B 00 00 00 00 00 00 00 00 00 00 00  // DATA1 with no payload
07 1 0 0C C3 31 32 33 34 35 36 37 38 39 C8 B4  // stuff error
08 2 0 0C C3 31 32 33 34 35 36 37 38 39 C8 B4  // CRC16 failure
09 2 0 03 69 00 10 00 00 00 00 00 00 00 00 00  // CRC5 failure
0A 0 0 03 D3 00 00 00 00 00 00 00 00 00 00 00  // PID nibbles not complements
0B 0 1 03 2D 00 10 00 00 00 00 00 00 00 00 00  // SETUP to address 0, endpoint 0

/* vlog.f */
rtl/usbLinePkg.sv
rtl/usbPacketPkg.sv
rtl/usbRxFrontend.sv
rtl/usbRxClockRecovery.sv
rtl/usbRxDecoder.sv
rtl/usbCrc.sv
rtl/usbRxOutput.sv
rtl/usbRxTop.sv
test/usbRxTb.sv

/* run.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module usbRxTb -f vlog.f -Mdir obj_dir -o usbRxSim \
    && obj_dir/usbRxSim | tee sim.log \
    && grep -q "RESULT: PASS" sim.log \
    || { echo "simulation did not pass"; exit 1; }
